// File: hdl/fpu_macros.svh
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// single precision layout
`define FPU_WIDTH      32
`define FPU_EXP_BITS   8
`define FPU_MAN_BITS   23

// min/max result when both operands are NaN
`define FPU_CANON_NAN  32'h7fc00000

`endif

// File: hdl/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

	// one code per loaded operation
	typedef enum logic [3:0] {
		op_sgnj   = 4'd0,
		op_sgnjn  = 4'd1,
		op_sgnjx  = 4'd2,
		op_feq    = 4'd3,
		op_flt    = 4'd4,
		op_fle    = 4'd5,
		op_fmin   = 4'd6,
		op_fmax   = 4'd7,
		op_fclass = 4'd8
	} fpu_op_t;

	// unit that drives result and iv
	typedef enum logic [2:0] {
		unit_none   = 3'd0,
		unit_sign   = 3'd1,
		unit_cmp    = 3'd2,
		unit_minmax = 3'd3,
		unit_class  = 3'd4
	} fpu_unit_t;

endpackage

`default_nettype wire

// File: hdl/float_fields_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

interface float_fields_if;

	logic                        sgn;
	logic [`FPU_EXP_BITS-1:0]    exp;
	logic [`FPU_MAN_BITS-1:0]    man;
	logic                        zero;
	logic                        inf;
	logic                        snan;
	logic                        qnan;
	logic                        denormal;

	modport source (output sgn, exp, man, zero, inf, snan, qnan, denormal);
	modport sink   (input  sgn, exp, man, zero, inf, snan, qnan, denormal);

endinterface

`default_nettype wire

// File: hdl/float_splitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module float_splitter (
	input  wire logic [`FPU_WIDTH-1:0] value,
	float_fields_if.source             fields
);

	logic exp_zero;
	logic exp_ones;
	logic man_zero;

	assign fields.sgn = value[`FPU_WIDTH-1];
	assign fields.exp = value[`FPU_WIDTH-2 -: `FPU_EXP_BITS];
	assign fields.man = value[`FPU_MAN_BITS-1:0];

	assign exp_zero = (fields.exp == '0);
	assign exp_ones = (fields.exp == '1);
	assign man_zero = (fields.man == '0);

	assign fields.zero     = exp_zero & man_zero;
	assign fields.denormal = exp_zero & ~man_zero;
	assign fields.inf      = exp_ones & man_zero;

	// quiet bit is the fraction msb
	assign fields.qnan = exp_ones & fields.man[`FPU_MAN_BITS-1];
	assign fields.snan = exp_ones & ~fields.man[`FPU_MAN_BITS-1] & ~man_zero;

endmodule

`default_nettype wire

// File: hdl/fpu_op_register.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module fpu_op_register (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  load,
	input  wire fpu_pkg::fpu_op_t      op,
	input  wire logic [`FPU_WIDTH-1:0] a,
	input  wire logic [`FPU_WIDTH-1:0] b,
	output logic [`FPU_WIDTH-1:0]      a_q,
	output logic [`FPU_WIDTH-1:0]      b_q,
	output fpu_pkg::fpu_op_t           op_q,
	output fpu_pkg::fpu_unit_t         unit_q,
	output logic                       ready
);

	fpu_pkg::fpu_unit_t unit_next;

	always_comb begin
		case (op)
			fpu_pkg::op_sgnj, fpu_pkg::op_sgnjn, fpu_pkg::op_sgnjx:
				unit_next = fpu_pkg::unit_sign;
			fpu_pkg::op_feq, fpu_pkg::op_flt, fpu_pkg::op_fle:
				unit_next = fpu_pkg::unit_cmp;
			fpu_pkg::op_fmin, fpu_pkg::op_fmax:
				unit_next = fpu_pkg::unit_minmax;
			fpu_pkg::op_fclass:
				unit_next = fpu_pkg::unit_class;
			default:
				unit_next = fpu_pkg::unit_none;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			op_q   <= fpu_pkg::op_sgnj;
			unit_q <= fpu_pkg::unit_none;
			ready  <= 1'b0;
		end else begin
			// one pulse per load, back to back allowed
			ready <= load;
			if (load) begin
				op_q   <= op;
				unit_q <= unit_next;
			end
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		if (load) begin
			a_q <= a;
			b_q <= b;
		end
	end

endmodule

`default_nettype wire

// File: hdl/sign_injector.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module sign_injector (
	input  wire fpu_pkg::fpu_op_t      op_q,
	input  wire logic [`FPU_WIDTH-1:0] a_q,
	input  wire logic                  sgn_b,
	output logic [`FPU_WIDTH-1:0]      value
);

	logic sgn_new;

	always_comb begin
		case (op_q)
			fpu_pkg::op_sgnj:  sgn_new = sgn_b;
			fpu_pkg::op_sgnjn: sgn_new = ~sgn_b;
			fpu_pkg::op_sgnjx: sgn_new = a_q[`FPU_WIDTH-1] ^ sgn_b;
			default:           sgn_new = a_q[`FPU_WIDTH-1];
		endcase
	end

	// payload bits untouched, NaNs included
	assign value = {sgn_new, a_q[`FPU_WIDTH-2:0]};

endmodule

`default_nettype wire

// File: hdl/float_compare.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module float_compare (
	input  wire fpu_pkg::fpu_op_t  op_q,
	float_fields_if.sink           fa,
	float_fields_if.sink           fb,
	output logic [`FPU_WIDTH-1:0]  value,
	output logic                   iv
);

	logic [`FPU_WIDTH-2:0] mag_a;
	logic [`FPU_WIDTH-2:0] mag_b;
	logic                  any_nan;
	logic                  any_snan;
	logic                  both_zero;
	logic                  mag_lt;
	logic                  mag_eq;
	logic                  eq;
	logic                  lt;
	logic                  bit_out;

	assign mag_a = {fa.exp, fa.man};
	assign mag_b = {fb.exp, fb.man};
	assign mag_lt = (mag_a < mag_b);
	assign mag_eq = (mag_a == mag_b);

	assign any_snan  = fa.snan | fb.snan;
	assign any_nan   = any_snan | fa.qnan | fb.qnan;
	assign both_zero = fa.zero & fb.zero;

	// +0 and -0 compare equal
	assign eq = both_zero | ((fa.sgn == fb.sgn) & mag_eq);

	always_comb begin
		if (both_zero)
			lt = 1'b0;
		else if (fa.sgn != fb.sgn)
			lt = fa.sgn;
		else if (!fa.sgn)
			lt = mag_lt;
		else
			lt = ~mag_lt & ~mag_eq;
	end

	always_comb begin
		bit_out = 1'b0;
		iv      = 1'b0;
		case (op_q)
			fpu_pkg::op_feq: begin
				bit_out = eq & ~any_nan;
				iv      = any_snan;
			end
			fpu_pkg::op_flt: begin
				bit_out = lt & ~any_nan;
				iv      = any_nan;
			end
			fpu_pkg::op_fle: begin
				bit_out = (lt | eq) & ~any_nan;
				iv      = any_nan;
			end
			default: begin
				bit_out = 1'b0;
				iv      = 1'b0;
			end
		endcase
	end

	assign value = {{(`FPU_WIDTH-1){1'b0}}, bit_out};

endmodule

`default_nettype wire

// File: hdl/min_max_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module min_max_select (
	input  wire fpu_pkg::fpu_op_t      op_q,
	input  wire logic [`FPU_WIDTH-1:0] a_q,
	input  wire logic [`FPU_WIDTH-1:0] b_q,
	float_fields_if.sink               fa,
	float_fields_if.sink               fb,
	output logic [`FPU_WIDTH-1:0]      value,
	output logic                       iv
);

	logic [`FPU_WIDTH-2:0] mag_a;
	logic [`FPU_WIDTH-2:0] mag_b;
	logic                  nan_a;
	logic                  nan_b;
	logic                  a_lt_b;
	logic                  is_max;

	assign mag_a = {fa.exp, fa.man};
	assign mag_b = {fb.exp, fb.man};
	assign nan_a = fa.snan | fa.qnan;
	assign nan_b = fb.snan | fb.qnan;
	assign is_max = (op_q == fpu_pkg::op_fmax);

	// sign first, so -0 orders below +0
	assign a_lt_b = (fa.sgn != fb.sgn) ? fa.sgn :
		(fa.sgn ? (mag_a > mag_b) : (mag_a < mag_b));

	always_comb begin
		if (nan_a && nan_b)
			value = `FPU_CANON_NAN;
		else if (nan_a)
			value = b_q;
		else if (nan_b)
			value = a_q;
		else if (is_max)
			value = a_lt_b ? b_q : a_q;
		else
			value = a_lt_b ? a_q : b_q;
	end

	assign iv = fa.snan | fb.snan;

endmodule

`default_nettype wire

// File: hdl/float_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module float_classifier (
	float_fields_if.sink          fa,
	output logic [`FPU_WIDTH-1:0] value
);

	logic [9:0] mask;

	always_comb begin
		mask = '0;
		if (fa.snan)
			mask[8] = 1'b1;
		else if (fa.qnan)
			mask[9] = 1'b1;
		else if (fa.inf)
			mask[fa.sgn ? 0 : 7] = 1'b1;
		else if (fa.zero)
			mask[fa.sgn ? 3 : 4] = 1'b1;
		else if (fa.denormal)
			mask[fa.sgn ? 2 : 5] = 1'b1;
		else
			// normal numbers
			mask[fa.sgn ? 1 : 6] = 1'b1;
	end

	assign value = {{(`FPU_WIDTH-10){1'b0}}, mask};

endmodule

`default_nettype wire

// File: hdl/fpu_misc_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module fpu_misc_core (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic                  load,
	input  wire fpu_pkg::fpu_op_t      op,
	input  wire logic [`FPU_WIDTH-1:0] a,
	input  wire logic [`FPU_WIDTH-1:0] b,
	output logic [`FPU_WIDTH-1:0]      result,
	output logic                       iv,
	output logic                       ready
);

	logic [`FPU_WIDTH-1:0] a_q;
	logic [`FPU_WIDTH-1:0] b_q;
	fpu_pkg::fpu_op_t      op_q;
	fpu_pkg::fpu_unit_t    unit_q;

	logic [`FPU_WIDTH-1:0] result_sign;
	logic [`FPU_WIDTH-1:0] result_cmp;
	logic [`FPU_WIDTH-1:0] result_minmax;
	logic [`FPU_WIDTH-1:0] result_class;
	logic                  iv_cmp;
	logic                  iv_minmax;

	float_fields_if fa ();
	float_fields_if fb ();

	fpu_op_register op_reg (
		.clk    (clk),
		.reset  (reset),
		.load   (load),
		.op     (op),
		.a      (a),
		.b      (b),
		.a_q    (a_q),
		.b_q    (b_q),
		.op_q   (op_q),
		.unit_q (unit_q),
		.ready  (ready)
	);

	float_splitter split_a (.value(a_q), .fields(fa));
	float_splitter split_b (.value(b_q), .fields(fb));

	sign_injector sign_inj (
		.op_q  (op_q),
		.a_q   (a_q),
		.sgn_b (fb.sgn),
		.value (result_sign)
	);

	float_compare cmp (
		.op_q  (op_q),
		.fa    (fa),
		.fb    (fb),
		.value (result_cmp),
		.iv    (iv_cmp)
	);

	min_max_select minmax (
		.op_q  (op_q),
		.a_q   (a_q),
		.b_q   (b_q),
		.fa    (fa),
		.fb    (fb),
		.value (result_minmax),
		.iv    (iv_minmax)
	);

	float_classifier classify (
		.fa    (fa),
		.value (result_class)
	);

	// unit_none covers reset and unused codes
	always_comb begin
		result = '0;
		iv     = 1'b0;
		case (unit_q)
			fpu_pkg::unit_sign: result = result_sign;
			fpu_pkg::unit_cmp: begin
				result = result_cmp;
				iv     = iv_cmp;
			end
			fpu_pkg::unit_minmax: begin
				result = result_minmax;
				iv     = iv_minmax;
			end
			fpu_pkg::unit_class: result = result_class;
			default: begin
				result = '0;
				iv     = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: sim/fpu_misc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_macros.svh"

module fpu_misc_tb;

	localparam int ready_timeout = 8;

	logic                  clk;
	logic                  reset;
	logic                  load;
	fpu_pkg::fpu_op_t      op;
	logic [`FPU_WIDTH-1:0] a;
	logic [`FPU_WIDTH-1:0] b;
	logic [`FPU_WIDTH-1:0] result;
	logic                  iv;
	logic                  ready;

	int          errors = 0;
	int          checks = 0;
	logic [31:0] rng = 32'hc122_c87d;
	logic [31:0] specials [16];

	fpu_misc_core uut (
		.clk    (clk),
		.reset  (reset),
		.load   (load),
		.op     (op),
		.a      (a),
		.b      (b),
		.result (result),
		.iv     (iv),
		.ready  (ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic is_nan(input logic [31:0] x);
		return (x[30:23] == 8'hff) && (x[22:0] != 23'h0);
	endfunction

	// strict order by value, -0 below +0
	function automatic logic below(input logic [31:0] x, input logic [31:0] y);
		if (x[31] != y[31])
			return x[31];
		if (x[31])
			return x[30:0] > y[30:0];
		return x[30:0] < y[30:0];
	endfunction

	function automatic logic [31:0] class_mask(input logic [31:0] x);
		int idx;
		if (is_nan(x))
			idx = x[22] ? 9 : 8;
		else if (x[30:23] == 8'hff)
			idx = x[31] ? 0 : 7;
		else if (x[30:23] == 8'h00)
			idx = (x[22:0] == 23'h0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
		else
			idx = x[31] ? 1 : 6;
		return 32'h1 << idx;
	endfunction

	// expected {iv, result}
	function automatic logic [32:0] expected_of(input logic [3:0] code,
			input logic [31:0] x, input logic [31:0] y);
		logic nan_x;
		logic nan_y;
		logic snan;
		logic zeros;
		logic lt;
		logic eq;
		nan_x = is_nan(x);
		nan_y = is_nan(y);
		snan  = (nan_x && !x[22]) || (nan_y && !y[22]);
		zeros = (x[30:0] == 31'h0) && (y[30:0] == 31'h0);
		eq    = zeros || (x == y);
		lt    = !zeros && below(x, y);
		case (code)
			fpu_pkg::op_sgnj:   return {1'b0, y[31], x[30:0]};
			fpu_pkg::op_sgnjn:  return {1'b0, ~y[31], x[30:0]};
			fpu_pkg::op_sgnjx:  return {1'b0, x[31] ^ y[31], x[30:0]};
			fpu_pkg::op_feq:    return {snan, 31'h0, !(nan_x || nan_y) && eq};
			fpu_pkg::op_flt:    return {nan_x || nan_y, 31'h0, !(nan_x || nan_y) && lt};
			fpu_pkg::op_fle:    return {nan_x || nan_y, 31'h0, !(nan_x || nan_y) && (lt || eq)};
			fpu_pkg::op_fmin, fpu_pkg::op_fmax: begin
				if (nan_x && nan_y)
					return {snan, `FPU_CANON_NAN};
				if (nan_x)
					return {snan, y};
				if (nan_y)
					return {snan, x};
				if (code == fpu_pkg::op_fmin)
					return {1'b0, below(x, y) ? x : y};
				return {1'b0, below(x, y) ? y : x};
			end
			fpu_pkg::op_fclass: return {1'b0, class_mask(x)};
			default:            return 33'h0;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_outputs(input logic [3:0] code, input logic [31:0] x,
			input logic [31:0] y);
		logic [32:0] exp;
		exp = expected_of(code, x, y);
		check_word($sformatf("result (op %0d, a %h, b %h)", code, x, y), result, exp[31:0]);
		check_word($sformatf("iv (op %0d, a %h, b %h)", code, x, y), {31'h0, iv},
			{31'h0, exp[32]});
	endtask

	task automatic wait_ready();
		int late;
		late = 0;
		@(negedge clk);
		while (!ready && late < ready_timeout) begin
			@(negedge clk);
			late++;
		end
		checks++;
		assert (late == 0) else begin
			errors++;
			$display("ready came %0d cycles after the expected cycle", late);
		end
		if (!ready) begin
			errors++;
			$display("timeout: no ready pulse within %0d cycles of load", ready_timeout);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("FAIL: see errors above");
			$finish;
		end
	endtask

	// one cycle later: pulse over, outputs held
	task automatic check_settled(input logic [31:0] held_result, input logic held_iv);
		@(negedge clk);
		checks++;
		assert (!ready) else begin
			errors++;
			$display("ready stayed high for more than one cycle");
		end
		check_word("result (held)", result, held_result);
		check_word("iv (held)", {31'h0, iv}, {31'h0, held_iv});
	endtask

	task automatic issue(input logic [3:0] code, input logic [31:0] x, input logic [31:0] y);
		logic [32:0] expect_val;
		expect_val = expected_of(code, x, y);
		@(posedge clk);
		load <= 1'b1;
		op   <= fpu_pkg::fpu_op_t'(code);
		a    <= x;
		b    <= y;
		@(posedge clk);
		load <= 1'b0;
		wait_ready();
		check_outputs(code, x, y);
		check_settled(expect_val[31:0], expect_val[32]);
	endtask

	task automatic back_to_back(input logic [3:0] code1, input logic [31:0] x1,
			input logic [31:0] y1, input logic [3:0] code2, input logic [31:0] x2,
			input logic [31:0] y2);
		logic [32:0] expect_last;
		expect_last = expected_of(code2, x2, y2);
		@(posedge clk);
		load <= 1'b1;
		op   <= fpu_pkg::fpu_op_t'(code1);
		a    <= x1;
		b    <= y1;
		@(posedge clk);
		op <= fpu_pkg::fpu_op_t'(code2);
		a  <= x2;
		b  <= y2;
		wait_ready();
		check_outputs(code1, x1, y1);
		@(posedge clk);
		load <= 1'b0;
		wait_ready();
		check_outputs(code2, x2, y2);
		check_settled(expect_last[31:0], expect_last[32]);
	endtask

	initial begin
		int          code;
		int          i;
		int          j;
		int          n;
		logic [3:0]  rcode;
		logic [3:0]  rcode2;
		logic [31:0] x;
		logic [31:0] y;

		reset = 1'b1;
		load  = 1'b0;
		op    = fpu_pkg::op_sgnj;
		a     = '0;
		b     = '0;

		specials[0]  = 32'h0000_0000;
		specials[1]  = 32'h8000_0000;
		specials[2]  = 32'h7f80_0000;
		specials[3]  = 32'hff80_0000;
		specials[4]  = 32'h7fc0_0000;
		specials[5]  = 32'hffc0_0001;
		specials[6]  = 32'h7f80_0001;
		specials[7]  = 32'hff90_0000;
		specials[8]  = 32'h0000_0001;
		specials[9]  = 32'h807f_ffff;
		specials[10] = 32'h3f80_0000;
		specials[11] = 32'hbf80_0000;
		specials[12] = 32'h7f7f_ffff;
		specials[13] = 32'hff7f_ffff;
		specials[14] = 32'h4049_0fdb;
		specials[15] = 32'hc049_0fdb;

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_word("ready after reset", {31'h0, ready}, 32'h0);
		check_word("iv after reset", {31'h0, iv}, 32'h0);
		check_word("result after reset", result, 32'h0);

		// every operation on every pair of special values
		for (code = 0; code < 9; code++)
			for (i = 0; i < 16; i++)
				for (j = 0; j < 16; j++)
					issue(code[3:0], specials[i[3:0]], specials[j[3:0]]);

		// unused codes
		for (code = 9; code < 16; code++) begin
			rng = xorshift32(rng);
			issue(code[3:0], specials[code[3:0]], rng);
		end

		for (n = 0; n < 24; n++) begin
			rng = xorshift32(rng);
			rcode = rng[3:0];
			rcode2 = rng[7:4];
			x = specials[rng[11:8]];
			rng = xorshift32(rng);
			y = rng;
			back_to_back(rcode, x, y, rcode2, y, specials[rng[31:28]]);
		end

		for (n = 0; n < 400; n++) begin
			rng = xorshift32(rng);
			rcode = 4'(rng % 32'd9);
			rng = xorshift32(rng);
			x = (rng[2:0] == 3'd0) ? specials[rng[31:28]] : rng;
			rng = xorshift32(rng);
			y = (rng[2:0] == 3'd0) ? specials[rng[31:28]] : rng;
			// same sign and exponent now and then
			if (rng[3])
				y = {x[31:23], y[22:0]};
			issue(rcode, x, y);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/fpu_pkg.sv
hdl/float_fields_if.sv
hdl/float_splitter.sv
hdl/fpu_op_register.sv
hdl/sign_injector.sv
hdl/float_compare.sv
hdl/min_max_select.sv
hdl/float_classifier.sv
hdl/fpu_misc_core.sv
sim/fpu_misc_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpu_misc_tb -f compile.f -o fpu_misc_sim

./obj_dir/fpu_misc_sim > sim.log
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
exit 1
